//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int data_w  = 24;
    localparam int shamt_w = 5;

    typedef logic [data_w-1:0] data_t;
    typedef logic [data_w-1:0] pc_t;
    typedef logic [3:0]        gp_idx_t;
    typedef logic [11:0]       imm12_t;
    typedef logic [15:0]       imm16_t;

    typedef enum logic [7:0] {
        NOP   = 8'h00,
        LUIui = 8'h01,
        MOVur = 8'h10,
        ADDur = 8'h11,
        SUBur = 8'h12,
        NOTur = 8'h13,
        ANDur = 8'h14,
        ORur  = 8'h15,
        XORur = 8'h16,
        SHLur = 8'h17,
        SHRur = 8'h18,
        CMPur = 8'h19,
        ADDsr = 8'h20,
        SUBsr = 8'h21,
        SHRsr = 8'h22,
        CMPsr = 8'h23,
        MOVui = 8'h30,
        ADDui = 8'h31,
        SUBui = 8'h32,
        ANDui = 8'h33,
        ORui  = 8'h34,
        XORui = 8'h35,
        SHLui = 8'h36,
        SHRui = 8'h37,
        CMPui = 8'h38,
        JCCui = 8'h40,
        BCCso = 8'h41,
        BALso = 8'h42
    } opc_e;

    typedef enum logic [3:0] {
        RA = 4'h0,
        EQ = 4'h1,
        NE = 4'h2,
        LT = 4'h3,
        GT = 4'h4,
        GE = 4'h5,
        LE = 4'h6,
        BT = 4'h7,
        AT = 4'h8,
        BE = 4'h9,
        AE = 4'hA
    } cc_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    // Everything handed on to the memory stage
    typedef struct packed {
        pc_t     pc;
        opc_e    opc;
        gp_idx_t tgt_gp;
        logic    tgt_gp_we;
        data_t   result;
        logic    branch_taken;
        pc_t     branch_pc;
    } ex_result_t;

endpackage

`default_nettype wire

//--- hdl/ex_alu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_alu_if;

    ex_pkg::opc_e   opc;
    ex_pkg::data_t  src_val;
    ex_pkg::data_t  tgt_val;
    ex_pkg::data_t  ir_val;
    ex_pkg::data_t  result;
    ex_pkg::flags_t flags_new;
    // Per-flag write mask
    ex_pkg::flags_t flags_we;

    modport imm (input opc, output ir_val);

    modport alu (input opc, src_val, tgt_val, ir_val, output result, flags_new, flags_we);

    modport sink (input opc, ir_val, result, flags_new, flags_we);

endinterface

`default_nettype wire

//--- hdl/ex_imm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_imm_unit (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           stall,
    input  ex_pkg::imm12_t imm12,
    ex_alu_if.imm          alu
);

    ex_pkg::imm12_t ui_latch;

    // Upper 12 bits for the next immediate op
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ui_latch <= '0;
        end else if (!stall && alu.opc == ex_pkg::LUIui) begin
            ui_latch <= imm12;
        end
    end

    assign alu.ir_val = {ui_latch, imm12};

endmodule

`default_nettype wire

//--- hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    ex_alu_if.alu alu
);

    localparam int msb = ex_pkg::data_w - 1;

    ex_pkg::data_t                 opb;
    ex_pkg::data_t                 sum;
    ex_pkg::data_t                 diff;
    ex_pkg::data_t                 res;
    ex_pkg::flags_t                fl_new;
    ex_pkg::flags_t                fl_we;
    logic [ex_pkg::shamt_w-1:0]    shamt;
    logic                          is_imm;
    logic                          is_shift;
    logic                          wr_res_z;
    logic                          add_ovf;
    logic                          sub_ovf;
    logic                          shift_ovf;

    assign is_imm = alu.opc inside {ex_pkg::MOVui, ex_pkg::ADDui, ex_pkg::SUBui,
                                    ex_pkg::ANDui, ex_pkg::ORui, ex_pkg::XORui,
                                    ex_pkg::SHLui, ex_pkg::SHRui, ex_pkg::CMPui};

    // Second operand from src register or widened immediate
    assign opb   = is_imm ? alu.ir_val : alu.src_val;
    assign sum   = alu.tgt_val + opb;
    assign diff  = alu.tgt_val - opb;
    assign shamt = opb[ex_pkg::shamt_w-1:0];

    assign shift_ovf = (opb >= ex_pkg::data_t'(ex_pkg::data_w));
    assign add_ovf   = (alu.tgt_val[msb] == opb[msb]) && (sum[msb] != alu.tgt_val[msb]);
    assign sub_ovf   = (alu.tgt_val[msb] != opb[msb]) && (diff[msb] != alu.tgt_val[msb]);

    always_comb begin
        res      = '0;
        fl_new   = '0;
        fl_we    = '0;
        is_shift = 1'b0;
        wr_res_z = 1'b0;
        case (alu.opc)
            ex_pkg::NOP, ex_pkg::LUIui, ex_pkg::JCCui, ex_pkg::BCCso, ex_pkg::BALso: begin
                res = '0;
            end
            ex_pkg::MOVur, ex_pkg::MOVui: begin
                res      = opb;
                wr_res_z = 1'b1;
            end
            ex_pkg::NOTur: begin
                res      = ~alu.tgt_val;
                wr_res_z = 1'b1;
            end
            ex_pkg::ANDur, ex_pkg::ANDui: begin
                res      = alu.tgt_val & opb;
                wr_res_z = 1'b1;
            end
            ex_pkg::ORur, ex_pkg::ORui: begin
                res      = alu.tgt_val | opb;
                wr_res_z = 1'b1;
            end
            ex_pkg::XORur, ex_pkg::XORui: begin
                res      = alu.tgt_val ^ opb;
                wr_res_z = 1'b1;
            end
            ex_pkg::ADDur, ex_pkg::ADDui: begin
                res      = sum;
                wr_res_z = 1'b1;
                // Carry out shows as wrap below the first operand
                fl_we.c  = 1'b1;
                fl_new.c = (sum < alu.tgt_val);
            end
            ex_pkg::SUBur, ex_pkg::SUBui: begin
                res      = diff;
                wr_res_z = 1'b1;
                fl_we.c  = 1'b1;
                fl_new.c = (alu.tgt_val < opb);
            end
            ex_pkg::CMPur, ex_pkg::CMPui: begin
                fl_we.z  = 1'b1;
                fl_we.c  = 1'b1;
                fl_new.z = (alu.tgt_val == opb);
                fl_new.c = (alu.tgt_val < opb);
            end
            ex_pkg::SHLur, ex_pkg::SHLui: begin
                is_shift = 1'b1;
                res      = shift_ovf ? '0 : (alu.tgt_val << shamt);
                wr_res_z = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.v = shift_ovf;
            end
            ex_pkg::SHRur, ex_pkg::SHRui: begin
                is_shift = 1'b1;
                res      = shift_ovf ? '0 : (alu.tgt_val >> shamt);
                wr_res_z = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.v = shift_ovf;
            end
            ex_pkg::ADDsr: begin
                res      = sum;
                wr_res_z = 1'b1;
                fl_we.n  = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.n = sum[msb];
                fl_new.v = add_ovf;
            end
            ex_pkg::SUBsr: begin
                res      = diff;
                wr_res_z = 1'b1;
                fl_we.n  = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.n = diff[msb];
                fl_new.v = sub_ovf;
            end
            ex_pkg::SHRsr: begin
                is_shift = 1'b1;
                res      = shift_ovf ? '0 : ex_pkg::data_t'($signed(alu.tgt_val) >>> shamt);
                wr_res_z = 1'b1;
                fl_we.n  = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.n = res[msb];
                fl_new.v = shift_ovf;
            end
            ex_pkg::CMPsr: begin
                fl_we.z  = 1'b1;
                fl_we.n  = 1'b1;
                fl_we.v  = 1'b1;
                fl_new.z = (alu.tgt_val == opb);
                fl_new.n = diff[msb];
                fl_new.v = sub_ovf;
            end
            default: begin
                // Illegal opcode wipes all flags
                fl_we = '1;
            end
        endcase
        if (wr_res_z) begin
            fl_we.z  = 1'b1;
            fl_new.z = (res == '0);
        end
    end

    assign alu.result    = res;
    assign alu.flags_new = fl_new;
    assign alu.flags_we  = fl_we;

    always_comb begin
        if (is_shift && fl_new.v) begin
            assert (alu.result == '0)
                else $error("shift overflow with non-zero result");
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           stall,
    input  ex_pkg::pc_t    pc,
    input  ex_pkg::imm12_t imm12,
    input  ex_pkg::imm16_t imm16,
    input  ex_pkg::cc_e    cc,
    ex_alu_if.sink         alu,
    output logic           branch_taken,
    output ex_pkg::pc_t    branch_pc
);

    ex_pkg::flags_t flags_q;
    ex_pkg::flags_t flags_nxt;
    ex_pkg::pc_t    target;
    logic           cond_ok;
    logic           ge;

    // Merge only the flags this op writes
    assign flags_nxt = (flags_q & ~alu.flags_we) | (alu.flags_new & alu.flags_we);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            flags_q <= '0;
        end else if (!stall) begin
            flags_q <= flags_nxt;
        end
    end

    assign ge = ~(flags_q.n ^ flags_q.v);

    always_comb begin
        case (cc)
            ex_pkg::RA: cond_ok = 1'b1;
            ex_pkg::EQ: cond_ok = flags_q.z;
            ex_pkg::NE: cond_ok = ~flags_q.z;
            ex_pkg::LT: cond_ok = ~ge;
            ex_pkg::GT: cond_ok = ~flags_q.z & ge;
            ex_pkg::GE: cond_ok = ge;
            ex_pkg::LE: cond_ok = flags_q.z | ~ge;
            ex_pkg::BT: cond_ok = flags_q.c;
            ex_pkg::AT: cond_ok = ~flags_q.z & ~flags_q.c;
            ex_pkg::BE: cond_ok = flags_q.c | flags_q.z;
            ex_pkg::AE: cond_ok = ~flags_q.c;
            default:    cond_ok = 1'b0;
        endcase
    end

    always_comb begin
        branch_taken = 1'b0;
        target       = '0;
        case (alu.opc)
            ex_pkg::JCCui: begin
                branch_taken = cond_ok;
                target       = alu.ir_val;
            end
            ex_pkg::BCCso: begin
                branch_taken = cond_ok;
                target       = pc + {{(ex_pkg::data_w-12){imm12[11]}}, imm12};
            end
            ex_pkg::BALso: begin
                branch_taken = 1'b1;
                target       = pc + {{(ex_pkg::data_w-16){imm16[15]}}, imm16};
            end
            default: begin
                branch_taken = 1'b0;
            end
        endcase
    end

    assign branch_pc = branch_taken ? target : '0;

    assert property (@(posedge iw_clk) disable iff (iw_rst)
        alu.opc == ex_pkg::BALso |-> branch_taken)
        else $error("BALso not taken");

endmodule

`default_nettype wire

//--- hdl/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic               stall,
    input  logic               flush,
    input  ex_pkg::ex_result_t d,
    output ex_pkg::ex_result_t q
);

    // Flush beats stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> (!q.tgt_gp_we && !q.branch_taken))
        else $error("flushed slot still carries a write or branch");

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic            iw_clk,
    input  logic            iw_rst,
    input  logic            stall,
    input  logic            flush,
    input  ex_pkg::pc_t     pc,
    input  ex_pkg::opc_e    opc,
    input  ex_pkg::imm12_t  imm12,
    input  ex_pkg::imm16_t  imm16,
    input  ex_pkg::cc_e     cc,
    input  ex_pkg::gp_idx_t tgt_gp,
    input  logic            tgt_gp_we,
    input  ex_pkg::data_t   src_gp_val,
    input  ex_pkg::data_t   tgt_gp_val,
    output ex_pkg::pc_t     out_pc,
    output ex_pkg::opc_e    out_opc,
    output ex_pkg::gp_idx_t out_tgt_gp,
    output logic            out_tgt_gp_we,
    output ex_pkg::data_t   result,
    output logic            branch_taken,
    output ex_pkg::pc_t     branch_pc
);

    ex_pkg::ex_result_t stage_d;
    ex_pkg::ex_result_t stage_q;
    logic               br_taken;
    ex_pkg::pc_t        br_pc;

    ex_alu_if alu_bus ();

    assign alu_bus.opc     = opc;
    assign alu_bus.src_val = src_gp_val;
    assign alu_bus.tgt_val = tgt_gp_val;

    ex_imm_unit u_imm (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .imm12  (imm12),
        .alu    (alu_bus.imm)
    );

    ex_alu u_alu (
        .alu (alu_bus.alu)
    );

    ex_branch_unit u_branch (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .pc           (pc),
        .imm12        (imm12),
        .imm16        (imm16),
        .cc           (cc),
        .alu          (alu_bus.sink),
        .branch_taken (br_taken),
        .branch_pc    (br_pc)
    );

    assign stage_d.pc           = pc;
    assign stage_d.opc          = opc;
    assign stage_d.tgt_gp       = tgt_gp;
    assign stage_d.tgt_gp_we    = tgt_gp_we;
    assign stage_d.result       = alu_bus.result;
    assign stage_d.branch_taken = br_taken;
    assign stage_d.branch_pc    = br_pc;

    ex_mem_reg u_ex_mem (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .flush  (flush),
        .d      (stage_d),
        .q      (stage_q)
    );

    assign out_pc        = stage_q.pc;
    assign out_opc       = stage_q.opc;
    assign out_tgt_gp    = stage_q.tgt_gp;
    assign out_tgt_gp_we = stage_q.tgt_gp_we;
    assign result        = stage_q.result;
    assign branch_taken  = stage_q.branch_taken;
    assign branch_pc     = stage_q.branch_pc;

endmodule

`default_nettype wire

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    localparam int n_alu    = 150;
    localparam int n_lui    = 10;
    localparam int n_signed = 50;
    localparam int n_shift  = 40;
    localparam int n_mix    = 100;
    localparam int n_bal    = 20;
    localparam int n_bad    = 10;
    // Instructions issued over all tests
    localparam int n_instr    = 2 * n_alu + 6 * n_lui + 2 * (25 + n_signed) + 2 * n_shift
                                + n_mix + n_bal + 3 * n_bad;
    localparam int max_cycles = 2 * n_instr + 400;

    logic               iw_clk;
    logic               iw_rst;
    logic               stall;
    logic               flush;
    ex_pkg::pc_t        pc;
    ex_pkg::opc_e       opc;
    ex_pkg::imm12_t     imm12;
    ex_pkg::imm16_t     imm16;
    ex_pkg::cc_e        cc;
    ex_pkg::gp_idx_t    tgt_gp;
    logic               tgt_gp_we;
    ex_pkg::data_t      src_gp_val;
    ex_pkg::data_t      tgt_gp_val;
    ex_pkg::pc_t        out_pc;
    ex_pkg::opc_e       out_opc;
    ex_pkg::gp_idx_t    out_tgt_gp;
    logic               out_tgt_gp_we;
    ex_pkg::data_t      result;
    logic               branch_taken;
    ex_pkg::pc_t        branch_pc;

    // Model of flags, upper-immediate latch and output register
    ex_pkg::flags_t     m_flags;
    ex_pkg::imm12_t     m_latch;
    ex_pkg::ex_result_t m_out;
    ex_pkg::ex_result_t exp_q[$];
    ex_pkg::pc_t        cur_pc;
    logic [31:0]        lcg_state;
    bit                 drain;
    int                 cycles;
    int                 n_checks;
    int                 errors;
    int                 test_errs;

    ex_pkg::opc_e  uops[19] = '{ex_pkg::MOVur, ex_pkg::ADDur, ex_pkg::SUBur, ex_pkg::NOTur,
                               ex_pkg::ANDur, ex_pkg::ORur, ex_pkg::XORur, ex_pkg::SHLur,
                               ex_pkg::SHRur, ex_pkg::CMPur, ex_pkg::MOVui, ex_pkg::ADDui,
                               ex_pkg::SUBui, ex_pkg::ANDui, ex_pkg::ORui, ex_pkg::XORui,
                               ex_pkg::SHLui, ex_pkg::SHRui, ex_pkg::CMPui};
    ex_pkg::opc_e  sops[3]  = '{ex_pkg::ADDsr, ex_pkg::SUBsr, ex_pkg::CMPsr};
    ex_pkg::opc_e  shops[3] = '{ex_pkg::SHLur, ex_pkg::SHRur, ex_pkg::SHRsr};
    ex_pkg::opc_e  mops[8]  = '{ex_pkg::LUIui, ex_pkg::MOVui, ex_pkg::ADDur, ex_pkg::SUBsr,
                               ex_pkg::SHLur, ex_pkg::CMPur, ex_pkg::JCCui, ex_pkg::BCCso};
    ex_pkg::opc_e  bad_ops[4] = '{ex_pkg::opc_e'(8'h02), ex_pkg::opc_e'(8'h50),
                                 ex_pkg::opc_e'(8'h7F), ex_pkg::opc_e'(8'hFF)};
    ex_pkg::cc_e   ucc[6]   = '{ex_pkg::EQ, ex_pkg::NE, ex_pkg::BT,
                               ex_pkg::AT, ex_pkg::BE, ex_pkg::AE};
    ex_pkg::cc_e   scc[4]   = '{ex_pkg::LT, ex_pkg::GE, ex_pkg::GT, ex_pkg::LE};
    ex_pkg::data_t edge_vals[5] = '{24'h7FFFFF, 24'h800000, 24'h000000, 24'h000001, 24'hFFFFFF};

    ex_stage i_dut (
        .iw_clk        (iw_clk),
        .iw_rst        (iw_rst),
        .stall         (stall),
        .flush         (flush),
        .pc            (pc),
        .opc           (opc),
        .imm12         (imm12),
        .imm16         (imm16),
        .cc            (cc),
        .tgt_gp        (tgt_gp),
        .tgt_gp_we     (tgt_gp_we),
        .src_gp_val    (src_gp_val),
        .tgt_gp_val    (tgt_gp_val),
        .out_pc        (out_pc),
        .out_opc       (out_opc),
        .out_tgt_gp    (out_tgt_gp),
        .out_tgt_gp_we (out_tgt_gp_we),
        .result        (result),
        .branch_taken  (branch_taken),
        .branch_pc     (branch_pc)
    );

    always #20 iw_clk = ~iw_clk;

    always @(posedge iw_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Run stopped: the tests did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic ex_pkg::data_t rnd();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:8];
    endfunction

    function automatic ex_pkg::imm12_t rnd12();
        ex_pkg::data_t v;
        v = rnd();
        return v[11:0];
    endfunction

    function automatic int pick(input int n);
        return int'({8'h00, rnd()}) % n;
    endfunction

    function automatic bit cond_holds(input ex_pkg::cc_e c, input ex_pkg::flags_t f);
        bit lt;
        lt = f.n ^ f.v;
        case (c)
            ex_pkg::RA: return 1'b1;
            ex_pkg::EQ: return f.z;
            ex_pkg::NE: return !f.z;
            ex_pkg::LT: return lt;
            ex_pkg::GE: return !lt;
            ex_pkg::GT: return !f.z && !lt;
            ex_pkg::LE: return f.z || lt;
            ex_pkg::BT: return f.c;
            ex_pkg::AE: return !f.c;
            ex_pkg::AT: return !f.z && !f.c;
            ex_pkg::BE: return f.c || f.z;
            default: return 1'b0;
        endcase
    endfunction

    // Expected stage output for one instruction and its next flags in f
    function automatic ex_pkg::ex_result_t ref_result(
        input  ex_pkg::opc_e   op,
        input  ex_pkg::cc_e    c,
        input  ex_pkg::data_t  s,
        input  ex_pkg::data_t  t,
        input  ex_pkg::imm12_t i12,
        input  ex_pkg::imm16_t i16,
        output ex_pkg::flags_t f
    );
        ex_pkg::ex_result_t r;
        ex_pkg::data_t      b;
        logic [24:0]        wide;
        int                 sum;
        bit                 has_res;
        r       = '0;
        f       = m_flags;
        has_res = 1'b1;
        r.pc    = cur_pc;
        r.opc   = op;
        if (op inside {ex_pkg::MOVui, ex_pkg::ADDui, ex_pkg::SUBui, ex_pkg::ANDui, ex_pkg::ORui,
                       ex_pkg::XORui, ex_pkg::SHLui, ex_pkg::SHRui, ex_pkg::CMPui}) begin
            b = {m_latch, i12};
        end else begin
            b = s;
        end
        case (op)
            ex_pkg::MOVur, ex_pkg::MOVui: r.result = b;
            ex_pkg::NOTur: r.result = ~t;
            ex_pkg::ANDur, ex_pkg::ANDui: r.result = t & b;
            ex_pkg::ORur, ex_pkg::ORui: r.result = t | b;
            ex_pkg::XORur, ex_pkg::XORui: r.result = t ^ b;
            ex_pkg::ADDur, ex_pkg::ADDui: begin
                wide     = {1'b0, t} + {1'b0, b};
                r.result = wide[23:0];
                f.c      = wide[24];
            end
            ex_pkg::SUBur, ex_pkg::SUBui: begin
                wide     = {1'b0, t} - {1'b0, b};
                r.result = wide[23:0];
                f.c      = wide[24];
            end
            ex_pkg::CMPur, ex_pkg::CMPui: begin
                wide    = {1'b0, t} - {1'b0, b};
                f.z     = (t == b);
                f.c     = wide[24];
                has_res = 1'b0;
            end
            ex_pkg::SHLur, ex_pkg::SHLui, ex_pkg::SHRur, ex_pkg::SHRui, ex_pkg::SHRsr: begin
                f.v = (b >= 24'd24);
                if (f.v) begin
                    r.result = '0;
                end else if (op == ex_pkg::SHLur || op == ex_pkg::SHLui) begin
                    r.result = t << b[4:0];
                end else if (op == ex_pkg::SHRsr) begin
                    r.result = $signed(t) >>> b[4:0];
                end else begin
                    r.result = t >> b[4:0];
                end
                if (op == ex_pkg::SHRsr) begin
                    f.n = r.result[23];
                end
            end
            ex_pkg::ADDsr, ex_pkg::SUBsr, ex_pkg::CMPsr: begin
                if (op == ex_pkg::ADDsr) begin
                    sum = int'($signed(t)) + int'($signed(b));
                end else begin
                    sum = int'($signed(t)) - int'($signed(b));
                end
                f.n = sum[23];
                f.v = (sum > 8388607) || (sum < -8388608);
                if (op == ex_pkg::CMPsr) begin
                    f.z     = (t == b);
                    has_res = 1'b0;
                end else begin
                    r.result = sum[23:0];
                end
            end
            ex_pkg::NOP, ex_pkg::LUIui, ex_pkg::JCCui, ex_pkg::BCCso, ex_pkg::BALso: begin
                has_res = 1'b0;
            end
            default: begin
                f       = '0;
                has_res = 1'b0;
            end
        endcase
        if (has_res) begin
            f.z = (r.result == '0);
        end
        case (op)
            ex_pkg::JCCui: begin
                r.branch_taken = cond_holds(c, m_flags);
                r.branch_pc    = {m_latch, i12};
            end
            ex_pkg::BCCso: begin
                r.branch_taken = cond_holds(c, m_flags);
                r.branch_pc    = cur_pc + ex_pkg::pc_t'($signed(i12));
            end
            ex_pkg::BALso: begin
                r.branch_taken = 1'b1;
                r.branch_pc    = cur_pc + ex_pkg::pc_t'($signed(i16));
            end
            default: begin
            end
        endcase
        if (!r.branch_taken) begin
            r.branch_pc = '0;
        end
        return r;
    endfunction

    task automatic check_data(input string what, input ex_pkg::data_t got,
                              input ex_pkg::data_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_branch(input logic got_t, input ex_pkg::pc_t got_pc,
                                input logic exp_t, input ex_pkg::pc_t exp_pc);
        n_checks++;
        if (got_t !== exp_t || got_pc !== exp_pc) begin
            errors++;
            test_errs++;
            $display("[FAIL] %0t ns: branch %b to %h, expected %b to %h",
                     $time, got_t, got_pc, exp_t, exp_pc);
        end
    endtask

    task automatic check_ctrl(input ex_pkg::gp_idx_t got_gp, input logic got_we,
                              input ex_pkg::opc_e got_op, input ex_pkg::gp_idx_t exp_gp,
                              input logic exp_we, input ex_pkg::opc_e exp_op);
        n_checks++;
        if (got_gp !== exp_gp || got_we !== exp_we || got_op !== exp_op) begin
            errors++;
            test_errs++;
            $display("[FAIL] %0t ns: ctrl gp %h we %b opc %h, expected gp %h we %b opc %h",
                     $time, got_gp, got_we, got_op, exp_gp, exp_we, exp_op);
        end
    endtask

    task automatic compare_out(input ex_pkg::ex_result_t e);
        check_data("result", result, e.result);
        check_data("out_pc", out_pc, e.pc);
        check_branch(branch_taken, branch_pc, e.branch_taken, e.branch_pc);
        check_ctrl(out_tgt_gp, out_tgt_gp_we, out_opc, e.tgt_gp, e.tgt_gp_we, e.opc);
    endtask

    task automatic check_reset_outputs();
        check_data("result in reset", result, '0);
        check_data("out_pc in reset", out_pc, '0);
        check_branch(branch_taken, branch_pc, 1'b0, '0);
        check_ctrl(out_tgt_gp, out_tgt_gp_we, out_opc, '0, 1'b0, ex_pkg::NOP);
    endtask

    task automatic issue(
        input ex_pkg::opc_e   op,
        input ex_pkg::cc_e    c,
        input ex_pkg::data_t  s,
        input ex_pkg::data_t  t,
        input ex_pkg::imm12_t i12,
        input ex_pkg::imm16_t i16,
        input bit             stl,
        input bit             fls
    );
        ex_pkg::ex_result_t e;
        ex_pkg::flags_t     nf;
        ex_pkg::data_t      r;
        r           = rnd();
        e           = ref_result(op, c, s, t, i12, i16, nf);
        e.tgt_gp    = r[3:0];
        e.tgt_gp_we = r[4];
        @(posedge iw_clk);
        stall      <= stl;
        flush      <= fls;
        pc         <= cur_pc;
        opc        <= op;
        imm12      <= i12;
        imm16      <= i16;
        cc         <= c;
        tgt_gp     <= r[3:0];
        tgt_gp_we  <= r[4];
        src_gp_val <= s;
        tgt_gp_val <= t;
        if (!stl) begin
            m_flags = nf;
            if (op == ex_pkg::LUIui) begin
                m_latch = i12;
            end
        end
        if (fls) begin
            m_out = '0;
        end else if (!stl) begin
            m_out = e;
        end
        exp_q.push_back(m_out);
        cur_pc = cur_pc + 24'd4;
    endtask

    task automatic alu_op(input ex_pkg::opc_e op, input ex_pkg::data_t s,
                          input ex_pkg::data_t t, input ex_pkg::imm12_t k);
        issue(op, ex_pkg::RA, s, t, k, 16'h0, 1'b0, 1'b0);
    endtask

    task automatic branch_op(input ex_pkg::opc_e op, input ex_pkg::cc_e c,
                             input ex_pkg::imm12_t k, input ex_pkg::imm16_t w);
        issue(op, c, 24'h0, 24'h0, k, w, 1'b0, 1'b0);
    endtask

    // Park the stage on stall and let the last results drain
    task automatic settle();
        @(posedge iw_clk);
        stall <= 1'b1;
        flush <= 1'b0;
        drain = 1'b1;
        while (exp_q.size() > 0) begin
            @(negedge iw_clk);
        end
        drain = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge iw_clk);
        iw_rst <= 1'b1;
        repeat (4) @(posedge iw_clk);
        @(negedge iw_clk);
        check_reset_outputs();
        @(posedge iw_clk);
        iw_rst <= 1'b0;
        m_flags = '0;
        m_latch = '0;
        m_out   = '0;
    endtask

    task automatic end_test(input string name);
        settle();
        $display("%-26s %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // An entry is due once the next instruction has been issued
    initial begin
        forever begin
            @(negedge iw_clk);
            if (exp_q.size() > 1 || (drain && exp_q.size() > 0)) begin
                compare_out(exp_q.pop_front());
            end
        end
    end

    initial begin
        ex_pkg::opc_e  op;
        ex_pkg::data_t s;
        ex_pkg::data_t t;
        ex_pkg::imm12_t k;
        iw_clk     = 1'b0;
        iw_rst     = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        pc         = '0;
        opc        = ex_pkg::NOP;
        imm12      = '0;
        imm16      = '0;
        cc         = ex_pkg::RA;
        tgt_gp     = '0;
        tgt_gp_we  = 1'b0;
        src_gp_val = '0;
        tgt_gp_val = '0;
        m_flags    = '0;
        m_latch    = '0;
        m_out      = '0;
        cur_pc     = 24'h000100;
        lcg_state  = 32'd96290;
        drain      = 1'b0;
        cycles     = 0;
        n_checks   = 0;
        errors     = 0;
        test_errs  = 0;
        apply_reset();

        for (int i = 0; i < n_alu; i++) begin
            op = uops[pick(19)];
            s  = rnd();
            t  = (pick(4) == 0) ? s : rnd();
            k  = rnd12();
            // Keep shift amounts near the 24 boundary
            if (op inside {ex_pkg::SHLur, ex_pkg::SHRur}) begin
                s = {19'h0, s[4:0]};
            end
            if (op inside {ex_pkg::SHLui, ex_pkg::SHRui}) begin
                k = {7'h0, k[4:0]};
            end
            alu_op(op, s, t, k);
            branch_op(ex_pkg::JCCui, ucc[pick(6)], rnd12(), 16'h0);
        end
        end_test("unsigned alu and jcc:");

        for (int i = 0; i < n_lui; i++) begin
            alu_op(ex_pkg::LUIui, 24'h0, 24'h0, rnd12());
            alu_op(ex_pkg::MOVui, rnd(), rnd(), rnd12());
            alu_op(ex_pkg::ADDur, rnd(), rnd(), rnd12());
            alu_op(ex_pkg::ADDui, rnd(), rnd(), rnd12());
            alu_op(ex_pkg::NOTur, rnd(), rnd(), rnd12());
            branch_op(ex_pkg::JCCui, ex_pkg::RA, rnd12(), 16'h0);
        end
        end_test("upper immediate:");

        for (int i = 0; i < 25 + n_signed; i++) begin
            if (i < 25) begin
                s = edge_vals[i % 5];
                t = edge_vals[i / 5];
            end else begin
                s = rnd();
                t = rnd();
            end
            alu_op(sops[pick(3)], s, t, 12'h0);
            branch_op(ex_pkg::BCCso, scc[pick(4)], rnd12(), 16'h0);
        end
        end_test("signed ops and bcc:");

        for (int i = 0; i < n_shift; i++) begin
            s = rnd();
            if (i % 2 == 0) begin
                s = {19'h0, s[4:0]} + 24'd24;
            end else begin
                s = {19'h0, s[4:0]};
            end
            alu_op(shops[pick(3)], s, rnd(), 12'h0);
            branch_op(ex_pkg::BCCso, (pick(2) == 0) ? ex_pkg::LT : ex_pkg::GE, rnd12(), 16'h0);
        end
        end_test("shift overflow:");

        for (int i = 0; i < n_mix; i++) begin
            op = mops[pick(8)];
            s  = rnd();
            issue(op, scc[pick(4)], rnd(), rnd(), rnd12(), s[15:0], pick(4) == 0, pick(8) == 0);
        end
        settle();
        apply_reset();
        end_test("stall, flush and reset:");

        for (int i = 0; i < n_bal; i++) begin
            s = rnd();
            branch_op(ex_pkg::BALso, scc[pick(4)], rnd12(), s[15:0]);
        end
        for (int i = 0; i < n_bad; i++) begin
            s = rnd();
            alu_op(ex_pkg::CMPur, s, s, 12'h0);
            alu_op(bad_ops[pick(4)], rnd(), rnd(), rnd12());
            branch_op(ex_pkg::JCCui, ex_pkg::EQ, rnd12(), 16'h0);
        end
        end_test("bal and illegal opcode:");

        $display("Summary: %0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/ex_pkg.sv
hdl/ex_alu_if.sv
hdl/ex_imm_unit.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
test/tb_ex_stage.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_ex_stage
FLIST = flist.f
MDIR  = obj_dir
LOG   = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(MDIR) $(LOG)
